// File: Bender.yml
package:
  name: cpu_top

sources:
  - logic/cpu_isa_pkg.sv
  - logic/cpu_core_pkg.sv
  - logic/clock_enable.sv
  - logic/cpu_alu.sv
  - logic/cpu_datapath.sv
  - logic/instruction_sequencer.sv
  - logic/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_top_asserts.sv
      - sim/cpu_top_tb.sv

// File: cpu_top.f
logic/cpu_isa_pkg.sv
logic/cpu_core_pkg.sv
logic/clock_enable.sv
logic/cpu_alu.sv
logic/cpu_datapath.sv
logic/instruction_sequencer.sv
logic/cpu_top.sv
sim/cpu_top_asserts.sv
sim/cpu_top_tb.sv

// File: logic/clock_enable.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enable #(
  parameter int CLOCK_DIVIDER = 12
) (
  input  logic clock_i,
  input  logic reset_i,
  output logic step_o
);

  localparam int COUNT_WIDTH = $clog2(CLOCK_DIVIDER);
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLOCK_DIVIDER - 1);

  logic [COUNT_WIDTH-1:0] count;

  if (CLOCK_DIVIDER < 2) begin : g_divider_check
    $error("CLOCK_DIVIDER must be at least 2");
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count <= '0;
    end else if (count == LAST_COUNT) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // High for one clock on the last count
  assign step_o = (count == LAST_COUNT);

endmodule : clock_enable

`default_nettype wire

// File: logic/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;
(
  input  alu_op_t op_i,
  input  data_t   a_i,
  input  data_t   b_i,
  input  status_t status_i,
  output data_t   result_o,
  output status_t status_o
);

  data_t      operand;
  logic       carry_in;
  logic [8:0] sum;
  logic       arithmetic;

  // One adder shared by ADC, SBC and CMP
  always_comb begin
    operand  = (op_i == ALU_ADC) ? b_i : ~b_i;
    carry_in = (op_i == ALU_CMP) ? 1'b1 : status_i.carry;
    sum      = {1'b0, a_i} + {1'b0, operand} + {8'd0, carry_in};
  end

  always_comb begin
    result_o   = sum[7:0];
    status_o   = status_i;
    arithmetic = 1'b0;

    case (op_i)
      ALU_ADC, ALU_SBC, ALU_CMP: begin
        arithmetic = 1'b1;
      end
      ALU_AND: result_o = a_i & b_i;
      ALU_EOR: result_o = a_i ^ b_i;
      ALU_ORA: result_o = a_i | b_i;
      default: ;
    endcase

    if (op_i != ALU_NONE) begin
      status_o.zero     = (result_o == '0);
      status_o.negative = result_o[7];
    end
    // Carry out of bit 7, also the no-borrow flag
    if (arithmetic) begin
      status_o.carry = sum[8];
    end
  end

endmodule : cpu_alu

`default_nettype wire

// File: logic/cpu_core_pkg.sv
`default_nettype none

package cpu_core_pkg;

  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  localparam addr_t RESET_VECTOR_LOW  = 16'hFFFC;
  localparam addr_t RESET_VECTOR_HIGH = 16'hFFFD;

  // Request held on the memory bus between steps
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  read;
    logic  write;
  } bus_req_t;

  typedef enum logic [2:0] {
    DEST_NONE,
    DEST_A,
    DEST_X,
    DEST_Y,
    DEST_SP
  } reg_dest_t;

  // Y is needed as a source by TYA
  typedef enum logic [2:0] {
    SRC_DATA,
    SRC_A,
    SRC_X,
    SRC_Y,
    SRC_SP
  } reg_src_t;

  typedef struct packed {
    reg_dest_t            dest;
    reg_src_t             src;
    cpu_isa_pkg::alu_op_t alu_op;
    logic                 flags_from_load;
    logic                 set_carry;
    logic                 clear_carry;
  } reg_ctrl_t;

endpackage : cpu_core_pkg

`default_nettype wire

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;
(
  input  logic      clock_i,
  input  logic      reset_i,
  input  logic      step_i,
  input  reg_ctrl_t ctrl_i,
  input  data_t     data_i,
  output data_t     accumulator_o
);

  data_t   accumulator;
  data_t   index_x;
  data_t   index_y;
  data_t   stack_pointer;
  status_t status;
  status_t next_status;
  data_t   load_value;
  data_t   alu_result;
  status_t alu_status;

  cpu_alu u_alu (
    .op_i     (ctrl_i.alu_op),
    .a_i      (accumulator),
    .b_i      (data_i),
    .status_i (status),
    .result_o (alu_result),
    .status_o (alu_status)
  );

  always_comb begin
    case (ctrl_i.src)
      SRC_A:   load_value = accumulator;
      SRC_X:   load_value = index_x;
      SRC_Y:   load_value = index_y;
      SRC_SP:  load_value = stack_pointer;
      default: load_value = data_i;
    endcase
    if (ctrl_i.alu_op != ALU_NONE) begin
      load_value = alu_result;
    end
  end

  always_comb begin
    next_status = status;
    if (ctrl_i.alu_op != ALU_NONE) begin
      next_status = alu_status;
    end
    if (ctrl_i.flags_from_load) begin
      next_status.zero     = (data_i == '0);
      next_status.negative = data_i[7];
    end
    if (ctrl_i.set_carry) begin
      next_status.carry = 1'b1;
    end
    if (ctrl_i.clear_carry) begin
      next_status.carry = 1'b0;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      accumulator   <= '0;
      index_x       <= '0;
      index_y       <= '0;
      stack_pointer <= '0;
      status        <= STATUS_RESET;
    end else if (step_i) begin
      case (ctrl_i.dest)
        DEST_A:  accumulator   <= load_value;
        DEST_X:  index_x       <= load_value;
        DEST_Y:  index_y       <= load_value;
        DEST_SP: stack_pointer <= load_value;
        default: ;
      endcase
      status <= next_status;
    end
  end

  assign accumulator_o = accumulator;

endmodule : cpu_datapath

`default_nettype wire

// File: logic/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  // 6502 encodings of the supported instructions
  typedef enum logic [7:0] {
    OP_NOP     = 8'hEA,
    OP_SEC     = 8'h38,
    OP_CLC     = 8'h18,
    OP_TAX     = 8'hAA,
    OP_TAY     = 8'hA8,
    OP_TXA     = 8'h8A,
    OP_TYA     = 8'h98,
    OP_TXS     = 8'h9A,
    OP_TSX     = 8'hBA,
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    OP_LDA_ZP  = 8'hA5,
    OP_LDX_ZP  = 8'hA6,
    OP_LDY_ZP  = 8'hA4,
    OP_STA_ZP  = 8'h85,
    OP_ADC_IMM = 8'h69,
    OP_SBC_IMM = 8'hE9,
    OP_CMP_IMM = 8'hC9,
    OP_AND_IMM = 8'h29,
    OP_EOR_IMM = 8'h49,
    OP_ORA_IMM = 8'h09,
    OP_JMP_ABS = 8'h4C
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADC  = 3'd0,
    ALU_SBC  = 3'd1,
    ALU_CMP  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_EOR  = 3'd4,
    ALU_ORA  = 3'd5,
    ALU_NONE = 3'd7
  } alu_op_t;

  // Field order gives the flag positions, bit 7 first
  typedef struct packed {
    logic negative;
    logic overflow;
    logic bit5;
    logic brk;
    logic decimal;
    logic irq_disable;
    logic zero;
    logic carry;
  } status_t;

  // Bit 5, break and IRQ disable set, as on the W65C02
  localparam status_t STATUS_RESET = 8'b0011_0100;

endpackage : cpu_isa_pkg

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import cpu_core_pkg::*;
#(
  parameter int CLOCK_DIVIDER = 12
) (
  input  logic  clock_i,
  input  logic  reset_i,
  input  data_t data_i,
  input  logic  data_valid_i,
  output data_t data_o,
  output addr_t address_o,
  output logic  bus_read_o,
  output logic  bus_write_o
);

  logic      step;
  bus_req_t  bus_req;
  reg_ctrl_t reg_ctrl;
  data_t     accumulator;

  clock_enable #(
    .CLOCK_DIVIDER (CLOCK_DIVIDER)
  ) u_clock_enable (
    .clock_i (clock_i),
    .reset_i (reset_i),
    .step_o  (step)
  );

  instruction_sequencer u_sequencer (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .step_i        (step),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .accumulator_i (accumulator),
    .bus_o         (bus_req),
    .ctrl_o        (reg_ctrl)
  );

  cpu_datapath u_datapath (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .step_i        (step),
    .ctrl_i        (reg_ctrl),
    .data_i        (data_i),
    .accumulator_o (accumulator)
  );

  assign address_o   = bus_req.addr;
  assign data_o      = bus_req.wdata;
  assign bus_read_o  = bus_req.read;
  assign bus_write_o = bus_req.write;

endmodule : cpu_top

`default_nettype wire

// File: logic/instruction_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_sequencer
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;
(
  input  logic      clock_i,
  input  logic      reset_i,
  input  logic      step_i,
  input  data_t     data_i,
  input  logic      data_valid_i,
  input  data_t     accumulator_i,
  output bus_req_t  bus_o,
  output reg_ctrl_t ctrl_o
);

  typedef enum logic [2:0] {
    STAGE_FETCH      = 3'd0,
    STAGE_OPERAND    = 3'd1,
    STAGE_OPERAND2   = 3'd2,
    STAGE_RESET_LOW  = 3'd6,
    STAGE_RESET_HIGH = 3'd7
  } stage_t;

  localparam reg_ctrl_t CTRL_IDLE = '{
    dest:            DEST_NONE,
    src:             SRC_DATA,
    alu_op:          ALU_NONE,
    flags_from_load: 1'b0,
    set_carry:       1'b0,
    clear_carry:     1'b0
  };

  stage_t   stage;
  stage_t   next_stage;
  opcode_t  opcode;
  opcode_t  next_opcode;
  addr_t    pc;
  addr_t    next_pc;
  addr_t    pc_inc;
  bus_req_t bus_q;
  bus_req_t next_bus;
  logic     ready;
  logic     fetch_next;

  function automatic reg_dest_t load_dest(opcode_t op);
    case (op)
      OP_LDX_IMM, OP_LDX_ZP: return DEST_X;
      OP_LDY_IMM, OP_LDY_ZP: return DEST_Y;
      default:               return DEST_A;
    endcase
  endfunction

  function automatic alu_op_t alu_select(opcode_t op);
    case (op)
      OP_ADC_IMM: return ALU_ADC;
      OP_SBC_IMM: return ALU_SBC;
      OP_CMP_IMM: return ALU_CMP;
      OP_AND_IMM: return ALU_AND;
      OP_EOR_IMM: return ALU_EOR;
      OP_ORA_IMM: return ALU_ORA;
      default:    return ALU_NONE;
    endcase
  endfunction

  always_comb begin
    pc_inc      = pc + 16'd1;
    // A pending read holds the stage until memory answers
    ready       = !bus_q.read || data_valid_i;
    next_stage  = stage;
    next_opcode = opcode;
    next_pc     = pc;
    next_bus    = bus_q;
    fetch_next  = 1'b0;
    ctrl_o      = CTRL_IDLE;

    if (ready) begin
      case (stage)
        STAGE_RESET_LOW: begin
          next_pc[7:0]  = data_i;
          next_bus.addr = RESET_VECTOR_HIGH;
          next_stage    = STAGE_RESET_HIGH;
        end
        STAGE_RESET_HIGH: begin
          next_pc[15:8] = data_i;
          next_bus.addr = {data_i, pc[7:0]};
          next_stage    = STAGE_FETCH;
        end
        STAGE_FETCH: begin
          next_opcode = opcode_t'(data_i);
          next_stage  = STAGE_OPERAND;
          case (opcode_t'(data_i))
            OP_NOP, OP_SEC, OP_CLC, OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX: begin
              // No operand byte, bus idle for one step
              next_bus.read = 1'b0;
            end
            default: begin
              next_pc       = pc_inc;
              next_bus.addr = pc_inc;
            end
          endcase
        end
        STAGE_OPERAND: begin
          fetch_next = 1'b1;
          case (opcode)
            OP_SEC: ctrl_o.set_carry = 1'b1;
            OP_CLC: ctrl_o.clear_carry = 1'b1;
            OP_TAX: begin
              ctrl_o.dest = DEST_X;
              ctrl_o.src  = SRC_A;
            end
            OP_TAY: begin
              ctrl_o.dest = DEST_Y;
              ctrl_o.src  = SRC_A;
            end
            OP_TXA: begin
              ctrl_o.dest = DEST_A;
              ctrl_o.src  = SRC_X;
            end
            OP_TYA: begin
              ctrl_o.dest = DEST_A;
              ctrl_o.src  = SRC_Y;
            end
            OP_TXS: begin
              ctrl_o.dest = DEST_SP;
              ctrl_o.src  = SRC_X;
            end
            OP_TSX: begin
              ctrl_o.dest = DEST_X;
              ctrl_o.src  = SRC_SP;
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
              ctrl_o.dest            = load_dest(opcode);
              ctrl_o.flags_from_load = 1'b1;
            end
            OP_ADC_IMM, OP_SBC_IMM, OP_CMP_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ORA_IMM: begin
              ctrl_o.alu_op = alu_select(opcode);
              // CMP keeps the accumulator
              if (opcode != OP_CMP_IMM) begin
                ctrl_o.dest = DEST_A;
              end
            end
            OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
              fetch_next    = 1'b0;
              next_bus.addr = {8'h00, data_i};
              next_stage    = STAGE_OPERAND2;
            end
            OP_STA_ZP: begin
              fetch_next     = 1'b0;
              next_bus.addr  = {8'h00, data_i};
              next_bus.wdata = accumulator_i;
              next_bus.read  = 1'b0;
              next_bus.write = 1'b1;
              next_stage     = STAGE_OPERAND2;
            end
            OP_JMP_ABS: begin
              fetch_next    = 1'b0;
              next_pc[7:0]  = data_i;
              next_bus.addr = pc_inc;
              next_stage    = STAGE_OPERAND2;
            end
            default: ;
          endcase
        end
        STAGE_OPERAND2: begin
          case (opcode)
            OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
              ctrl_o.dest            = load_dest(opcode);
              ctrl_o.flags_from_load = 1'b1;
              fetch_next             = 1'b1;
            end
            OP_JMP_ABS: begin
              next_pc[15:8] = data_i;
              next_bus.addr = {data_i, pc[7:0]};
              next_stage    = STAGE_FETCH;
            end
            // End of the STA write step
            default: fetch_next = 1'b1;
          endcase
        end
        default: fetch_next = 1'b1;
      endcase
    end

    // Next opcode follows the last byte of this instruction
    if (fetch_next) begin
      next_pc        = pc_inc;
      next_bus.addr  = pc_inc;
      next_bus.read  = 1'b1;
      next_bus.write = 1'b0;
      next_stage     = STAGE_FETCH;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage       <= STAGE_RESET_LOW;
      bus_q.addr  <= RESET_VECTOR_LOW;
      bus_q.read  <= 1'b1;
      bus_q.write <= 1'b0;
    end else if (step_i) begin
      stage <= next_stage;
      bus_q <= next_bus;
    end
  end

  always_ff @(posedge clock_i) begin
    if (step_i) begin
      opcode <= next_opcode;
      pc     <= next_pc;
    end
  end

  assign bus_o = bus_q;

endmodule : instruction_sequencer

`default_nettype wire

// File: sim/cpu_top_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top_asserts
  import cpu_core_pkg::*;
#(
  parameter int CLOCK_DIVIDER = 12
) (
  input logic  clock_i,
  input logic  reset_i,
  input logic  step_i,
  input addr_t address_i,
  input logic  bus_read_i,
  input logic  bus_write_i
);

  int unsigned fail_count = 0;

  read_write_exclusive: assert property (
    @(posedge clock_i) disable iff (reset_i)
    !(bus_read_i && bus_write_i)
  ) else begin
    fail_count++;
    $error("Bus read and write strobes high together");
  end

  // Bus registers move only on a step
  bus_changes_on_step: assert property (
    @(posedge clock_i) disable iff (reset_i)
    !$past(step_i) |-> $stable({address_i, bus_read_i, bus_write_i})
  ) else begin
    fail_count++;
    $error("Bus outputs changed without a step");
  end

  write_in_zero_page: assert property (
    @(posedge clock_i) disable iff (reset_i)
    bus_write_i |-> address_i[15:8] == 8'h00
  ) else begin
    fail_count++;
    $error("Write outside page zero at %h", address_i);
  end

  write_lasts_one_step: assert property (
    @(posedge clock_i) disable iff (reset_i)
    $rose(bus_write_i) |-> bus_write_i [*CLOCK_DIVIDER] ##1 !bus_write_i
  ) else begin
    fail_count++;
    $error("Write strobe length differs from one step");
  end

endmodule : cpu_top_asserts

bind cpu_top cpu_top_asserts #(
  .CLOCK_DIVIDER (CLOCK_DIVIDER)
) u_asserts (
  .clock_i     (clock_i),
  .reset_i     (reset_i),
  .step_i      (step),
  .address_i   (address_o),
  .bus_read_i  (bus_read_o),
  .bus_write_i (bus_write_o)
);

`default_nettype wire

// File: sim/cpu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;
();

  localparam int          CLOCK_DIVIDER = 4;
  localparam int          RESET_CYCLES  = 10;
  localparam int unsigned SEED          = 32'h69015f6b;
  localparam addr_t       JUMP_TARGET   = 16'h0300;

  typedef struct packed {
    addr_t      addr;
    data_t      data;
    logic [2:0] test;
  } write_t;

  logic  clock;
  logic  reset;
  data_t read_data;
  logic  data_valid;
  data_t write_data;
  addr_t address;
  logic  bus_read;
  logic  bus_write;

  data_t  mem [0:65535];
  write_t expected[$];
  addr_t  reads[$];
  string  test_name [1:6];
  int     pending [1:6] = '{default: 0};
  int     test_fail [1:6] = '{default: 0};

  // Architectural state predicted while the program is built
  data_t model_a;
  data_t model_x;
  data_t model_y;
  data_t model_sp;
  logic  model_c;
  addr_t build_pc;
  int    build_test;
  int    instr_count = 0;
  addr_t jump_addr;

  int    passed = 0;
  int    failed = 0;
  int    write_errors = 0;
  int    stray_writes = 0;
  int    wait_cycles = 0;
  int    cycles = 0;
  int    limit;
  int    protocol_errors;
  logic  jump_seen = 1'b0;
  logic  write_seen = 1'b0;
  logic  timed_out = 1'b0;
  logic  stall_pending = 1'b0;
  addr_t stall_addr;
  addr_t last_read = '0;

  cpu_top #(
    .CLOCK_DIVIDER (CLOCK_DIVIDER)
  ) UUT (
    .clock_i      (clock),
    .reset_i      (reset),
    .data_i       (read_data),
    .data_valid_i (data_valid),
    .data_o       (write_data),
    .address_o    (address),
    .bus_read_o   (bus_read),
    .bus_write_o  (bus_write)
  );

  always #5 clock = ~clock;

  function automatic logic [8:0] add_with_carry(data_t a, data_t b, logic c);
    return 9'(a) + 9'(b) + 9'(c);
  endfunction

  task automatic emit_byte(data_t b);
    mem[build_pc] = b;
    build_pc = build_pc + 16'd1;
  endtask

  // Places one instruction and updates the predicted state
  task automatic add_instr(opcode_t op, addr_t arg = '0);
    data_t  v;
    write_t w;
    v = arg[7:0];
    instr_count++;
    emit_byte(op);
    case (op)
      OP_NOP, OP_SEC, OP_CLC, OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX: ;
      OP_JMP_ABS: begin
        emit_byte(arg[7:0]);
        emit_byte(arg[15:8]);
      end
      default: emit_byte(v);
    endcase
    case (op)
      OP_SEC:     model_c = 1'b1;
      OP_CLC:     model_c = 1'b0;
      OP_TAX:     model_x = model_a;
      OP_TAY:     model_y = model_a;
      OP_TXA:     model_a = model_x;
      OP_TYA:     model_a = model_y;
      OP_TXS:     model_sp = model_x;
      OP_TSX:     model_x = model_sp;
      OP_LDA_IMM: model_a = v;
      OP_LDX_IMM: model_x = v;
      OP_LDY_IMM: model_y = v;
      OP_LDA_ZP:  model_a = mem[{8'h00, v}];
      OP_LDX_ZP:  model_x = mem[{8'h00, v}];
      OP_LDY_ZP:  model_y = mem[{8'h00, v}];
      OP_ADC_IMM: {model_c, model_a} = add_with_carry(model_a, v, model_c);
      OP_SBC_IMM: {model_c, model_a} = add_with_carry(model_a, ~v, model_c);
      OP_CMP_IMM: model_c = (model_a >= v);
      OP_AND_IMM: model_a = model_a & v;
      OP_EOR_IMM: model_a = model_a ^ v;
      OP_ORA_IMM: model_a = model_a | v;
      OP_STA_ZP: begin
        w.addr = {8'h00, v};
        w.data = model_a;
        w.test = 3'(build_test);
        expected.push_back(w);
        pending[build_test]++;
      end
      OP_JMP_ABS: build_pc = arg;
      default: ;
    endcase
  endtask

  task automatic load_program();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = data_t'((i >> 8) * 29 + i) ^ 8'h6C;
    end
    mem[RESET_VECTOR_LOW]  = 8'h00;
    mem[RESET_VECTOR_HIGH] = 8'h02;
    model_a  = '0;
    model_x  = '0;
    model_y  = '0;
    model_sp = '0;
    model_c  = STATUS_RESET.carry;
    build_pc = 16'h0200;

    build_test = 2;
    add_instr(OP_LDA_IMM, 16'h3C);
    add_instr(OP_STA_ZP, 16'h10);
    add_instr(OP_LDX_IMM, 16'hC5);
    add_instr(OP_TXA);
    add_instr(OP_STA_ZP, 16'h11);
    add_instr(OP_LDY_IMM, 16'h7E);
    add_instr(OP_TYA);
    add_instr(OP_STA_ZP, 16'h12);
    add_instr(OP_LDA_ZP, 16'h80);
    add_instr(OP_STA_ZP, 16'h13);
    add_instr(OP_LDX_ZP, 16'h81);
    add_instr(OP_TXA);
    add_instr(OP_STA_ZP, 16'h14);
    add_instr(OP_LDY_ZP, 16'h82);
    add_instr(OP_TYA);
    add_instr(OP_STA_ZP, 16'h15);

    build_test = 3;
    add_instr(OP_SEC);
    add_instr(OP_LDA_IMM, 16'hF0);
    add_instr(OP_ADC_IMM, 16'h20);
    add_instr(OP_STA_ZP, 16'h20);
    add_instr(OP_CLC);
    add_instr(OP_ADC_IMM, 16'h05);
    add_instr(OP_STA_ZP, 16'h21);
    add_instr(OP_SEC);
    add_instr(OP_SBC_IMM, 16'h10);
    add_instr(OP_STA_ZP, 16'h22);
    add_instr(OP_CLC);
    add_instr(OP_SBC_IMM, 16'h40);
    add_instr(OP_STA_ZP, 16'h23);
    add_instr(OP_LDA_IMM, 16'h42);
    add_instr(OP_CMP_IMM, 16'h42);
    add_instr(OP_ADC_IMM, 16'h00);
    add_instr(OP_STA_ZP, 16'h24);
    add_instr(OP_CMP_IMM, 16'h90);
    add_instr(OP_ADC_IMM, 16'h00);
    add_instr(OP_STA_ZP, 16'h25);

    build_test = 4;
    add_instr(OP_LDA_IMM, 16'hF3);
    add_instr(OP_AND_IMM, 16'h3C);
    add_instr(OP_STA_ZP, 16'h30);
    add_instr(OP_EOR_IMM, 16'hFF);
    add_instr(OP_STA_ZP, 16'h31);
    add_instr(OP_ORA_IMM, 16'h10);
    add_instr(OP_STA_ZP, 16'h32);
    add_instr(OP_TAX);
    add_instr(OP_TAY);
    add_instr(OP_LDA_IMM, 16'h00);
    add_instr(OP_TXA);
    add_instr(OP_STA_ZP, 16'h33);
    add_instr(OP_LDA_IMM, 16'h00);
    add_instr(OP_TYA);
    add_instr(OP_STA_ZP, 16'h34);
    add_instr(OP_LDX_IMM, 16'h9B);
    add_instr(OP_TXS);
    add_instr(OP_LDX_IMM, 16'h00);
    add_instr(OP_TSX);
    add_instr(OP_NOP);
    add_instr(OP_TXA);
    add_instr(OP_STA_ZP, 16'h35);

    // Marker code at the jump target, then a loop on itself
    build_test = 5;
    jump_addr  = build_pc;
    add_instr(OP_JMP_ABS, JUMP_TARGET);
    add_instr(OP_LDA_IMM, 16'hA5);
    add_instr(OP_STA_ZP, 16'h40);
    add_instr(OP_JMP_ABS, build_pc);
  endtask

  task automatic flag_value(int test, string what, addr_t got, addr_t exp);
    $display("[FAIL] t=%0t: %s was %h, expected %h", $time, what, got, exp);
    test_fail[test]++;
  endtask

  task automatic finish_test(int test);
    if (test_fail[test] == 0) begin
      passed++;
      $display("Test %0d (%s): passed", test, test_name[test]);
    end else begin
      failed++;
      $display("Test %0d (%s): %0d errors", test, test_name[test], test_fail[test]);
    end
  endtask

  task automatic check_reset_vector();
    assert (reads[0] == RESET_VECTOR_LOW) else flag_value(1, "first read", reads[0], 16'hFFFC);
    assert (reads[1] == RESET_VECTOR_HIGH) else flag_value(1, "second read", reads[1], 16'hFFFD);
    assert (reads[2] == 16'h0200) else flag_value(1, "first fetch", reads[2], 16'h0200);
    finish_test(1);
  endtask

  task automatic check_write();
    write_t w;
    if (expected.size() == 0) begin
      $display("Unexpected write of %h to %h at t=%0t", write_data, address, $time);
      stray_writes++;
    end else begin
      w = expected.pop_front();
      assert (address == w.addr) else begin
        flag_value(w.test, "write address", address, w.addr);
        write_errors++;
      end
      assert (write_data == w.data) else begin
        flag_value(w.test, "write data", write_data, w.data);
        write_errors++;
      end
      if (w.test == 5) begin
        assert (jump_seen) else begin
          $display("Marker stored before the jump was taken at t=%0t", $time);
          test_fail[5]++;
        end
      end
      pending[w.test]--;
      if (pending[w.test] == 0) begin
        finish_test(w.test);
      end
    end
  endtask

  // Memory model with random wait states
  initial begin
    void'($urandom(SEED));
    forever begin
      @(posedge clock);
      if (bus_read) begin
        read_data <= mem[address];
      end
      data_valid <= ($urandom() % 4) != 0;
      if (bus_write) begin
        mem[address] <= write_data;
      end
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      // A step without valid data must leave the read request in place
      if (stall_pending) begin
        assert (bus_read && address == stall_addr) else begin
          flag_value(6, "address after a stalled read", address, stall_addr);
        end
        stall_pending = 1'b0;
      end
      if (UUT.step && bus_read && !data_valid) begin
        wait_cycles++;
        stall_pending = 1'b1;
        stall_addr    = address;
      end
      if (bus_read && address != last_read) begin
        // First read after the high operand byte of the jump
        if (last_read == jump_addr + 16'd2) begin
          assert (address == JUMP_TARGET) else begin
            flag_value(5, "read after JMP", address, JUMP_TARGET);
          end
          jump_seen = 1'b1;
        end
        last_read = address;
      end
      if (bus_read && reads.size() < 3) begin
        if (reads.size() == 0 || reads[$] != address) begin
          reads.push_back(address);
          if (reads.size() == 3) begin
            check_reset_vector();
          end
        end
      end
      if (bus_write && !write_seen) begin
        check_write();
      end
      write_seen = bus_write;
    end
  end

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    read_data    = '0;
    data_valid   = 1'b0;
    test_name[1] = "reset vector";
    test_name[2] = "loads and stores";
    test_name[3] = "arithmetic";
    test_name[4] = "logic and transfers";
    test_name[5] = "jump";
    test_name[6] = "back-pressure";
    load_program();
    limit = instr_count * 3 * CLOCK_DIVIDER * 8;

    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    while (expected.size() != 0 && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end

    if (expected.size() != 0) begin
      timed_out = 1'b1;
      $display("Run timed out after %0d cycles with %0d writes outstanding",
               cycles, expected.size());
    end else begin
      assert (write_errors == 0 && stray_writes == 0) else begin
        $display("Writes arrived out of order or with wrong data under wait states");
        test_fail[6]++;
      end
      assert (wait_cycles > 0) else begin
        $display("data_valid was never low in a step with a pending read");
        test_fail[6]++;
      end
      finish_test(6);
    end

    protocol_errors = UUT.u_asserts.fail_count;
    $display("Summary: %0d tests passed, %0d failed, %0d protocol assertion failures",
             passed, failed, protocol_errors);
    if (!timed_out && failed == 0 && protocol_errors == 0 && stray_writes == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : cpu_top_tb

`default_nettype wire
